// ==== store_queue_mem.f ====
+incdir+hdl
hdl/sq_pkg.sv
hdl/store_queue.sv
hdl/load_unit.sv
hdl/mem_arbiter.sv
hdl/data_memory.sv
hdl/store_queue_mem_top.sv
testbench/store_queue_mem_checker.sv
testbench/tb_store_queue_mem.sv

// ==== Makefile ====
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_store_queue_mem
FILELIST  := store_queue_mem.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_store_queue_mem.sv ====
`timescale 1ns/1ps
`include "sq_defs.svh"

module tb_store_queue_mem;

    import sq_pkg::*;

    localparam int OPEN_W       = $clog2(`SQ_DISPATCH_WIDTH + 1);
    localparam int MEM_AW       = $clog2(`SQ_MEM_WORDS * 4);  // byte address bits of the memory
    localparam int LOAD_TIMEOUT = 20;                        // cycles a load may wait for done
    // about 70 stores of up to 8 cycles and 30 loads of their timeout plus 4, with margin
    localparam int WATCHDOG_CYCLES = 80 * 8 + 40 * (LOAD_TIMEOUT + 4) + 50;

    logic              clock = 1'b0;
    logic              reset;
    logic [OPEN_W-1:0] num_store_dispatched;
    logic              issue_valid;
    sq_issue_t         issue_pkt;
    logic              start_store;
    logic              br_en;
    sq_index_t         br_tail;
    logic [OPEN_W-1:0] open_entries;
    sq_index_t         sq_head;
    sq_index_t         sq_tail;
    logic              load_valid;
    ld_req_t           load_req;
    logic              load_ready;
    logic              load_done;
    logic [31:0]       load_data;

    logic [7:0]  ref_mem [2**MEM_AW];    // byte image of what the data memory should hold
    logic [31:0] slot_addr [`SQ_DEPTH];  // what was issued into each slot
    logic [31:0] slot_data [`SQ_DEPTH];
    mem_size_t   slot_size [`SQ_DEPTH];
    sq_index_t   model_head = '0;
    sq_index_t   model_tail = '0;        // the dispatch side's own view of the tail
    logic [31:0] lcg_state = 32'd2;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          done_count = 0;
    logic [31:0] done_data;
    logic        done_ready;

    store_queue_mem_top i_dut (.*);

    always #5 clock = ~clock;

    // count load_done pulses away from the rising edge and keep what came with them
    always @(negedge clock) begin
        if (load_done === 1'b1) begin
            done_count++;
            done_data  = load_data;
            done_ready = load_ready;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int size_bytes(input mem_size_t size);
        return (size == MEM_BYTE) ? 1 : (size == MEM_HALF) ? 2 : 4;
    endfunction

    // little-endian, the address wraps on the memory's byte size
    function automatic void apply_store(input logic [31:0] addr, input logic [31:0] data,
                                        input mem_size_t size);
        for (int i = 0; i < size_bytes(size); i++) begin
            ref_mem[MEM_AW'(addr + 32'(i))] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] addr, input mem_size_t size);
        logic [31:0] value;
        value = '0;  // zero extension above the access size
        for (int i = 0; i < size_bytes(size); i++) begin
            value[8*i +: 8] = ref_mem[MEM_AW'(addr + 32'(i))];
        end
        return value;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        checks++;
        assert (got === expected) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) $display("%s: ok", name);
        else $display("%s: FAILED with %0d errors", name, errors - err_start);
    endtask

    task automatic dispatch_stores(input int n);
        @(posedge clock);
        num_store_dispatched <= OPEN_W'(n);
        @(posedge clock);
        num_store_dispatched <= '0;
        model_tail = model_tail + sq_index_t'(n);  // slots are handed out from the old tail
    endtask

    task automatic issue_store(input sq_index_t idx, input logic [31:0] addr,
                               input logic [31:0] data, input mem_size_t size);
        sq_issue_t   pkt;
        logic [31:0] r;
        r          = lcg_next();
        pkt.index  = idx;
        pkt.offset = {24'd0, r[23:16]};  // random split, the queue must add it back
        pkt.base   = addr - pkt.offset;
        pkt.data   = data;
        pkt.size   = size;
        slot_addr[idx] = addr;
        slot_data[idx] = data;
        slot_size[idx] = size;
        @(posedge clock);
        issue_valid <= 1'b1;
        issue_pkt   <= pkt;
        @(posedge clock);
        issue_valid <= 1'b0;
    endtask

    task automatic retire_store();
        @(posedge clock);
        start_store <= 1'b1;
        @(posedge clock);
        start_store <= 1'b0;
        // the head store was written to memory at this edge
        apply_store(slot_addr[model_head], slot_data[model_head], slot_size[model_head]);
        model_head = model_head + sq_index_t'(1);
    endtask

    task automatic store_one(input logic [31:0] addr, input logic [31:0] data,
                             input mem_size_t size);
        sq_index_t idx;
        idx = model_tail;
        dispatch_stores(1);
        issue_store(idx, addr, data, size);
        retire_store();
    endtask

    // two stores in one dispatch group, the younger one issued first
    task automatic store_pair(input logic [31:0] a0, input logic [31:0] d0, input mem_size_t s0,
                              input logic [31:0] a1, input logic [31:0] d1, input mem_size_t s1);
        sq_index_t idx;
        idx = model_tail;
        dispatch_stores(2);
        issue_store(idx + sq_index_t'(1), a1, d1, s1);
        issue_store(idx, a0, d0, s0);
        retire_store();
        retire_store();
    endtask

    task automatic run_load(input logic [31:0] addr, input mem_size_t size,
                            input sq_index_t snapshot, output logic [31:0] got);
        ld_req_t req;
        int      start_count;
        int      cycles;
        req.addr    = addr;
        req.size    = size;
        req.sq_tail = snapshot;
        start_count = done_count;
        cycles      = 0;
        @(negedge clock);
        check_value(32'(load_ready), 32'd1, "load_ready before a load");
        @(posedge clock);
        load_valid <= 1'b1;
        load_req   <= req;
        @(posedge clock);
        load_valid <= 1'b0;
        while (done_count == start_count && cycles < LOAD_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        got = done_data;
        if (done_count == start_count) begin
            $display("load from %h: no load_done within %0d cycles at %0t",
                     addr, LOAD_TIMEOUT, $time);
            errors++;
        end else begin
            check_value(32'(done_ready), 32'd1, "load_ready with load_done");
            check_value(got, ref_load(addr, size), $sformatf("load_data from %h", addr));
        end
    endtask

    task automatic test_reset();
        int err_start = errors;
        @(negedge clock);
        check_value(32'(open_entries), 32'(`SQ_DISPATCH_WIDTH), "open_entries after reset");
        check_value(32'(load_ready), 32'd1, "load_ready after reset");
        check_value(32'(load_done), 32'd0, "load_done after reset");
        check_value(32'(sq_head), 32'd0, "sq_head after reset");
        check_value(32'(sq_tail), 32'd0, "sq_tail after reset");
        report_test("reset", err_start);
    endtask

    task automatic test_word();
        int          err_start = errors;
        sq_index_t   idx;
        logic [31:0] got;
        idx = model_tail;
        dispatch_stores(1);
        @(negedge clock);
        check_value(32'(sq_tail), 32'(model_tail), "sq_tail after dispatch");
        issue_store(idx, 32'h100, 32'hDEADBEEF, MEM_WORD);
        retire_store();
        run_load(32'h100, MEM_WORD, model_tail, got);
        check_value(got, 32'hDEADBEEF, "word read back");
        report_test("word", err_start);
    endtask

    task automatic test_merge();
        int          err_start = errors;
        logic [31:0] got;
        // upper data bits are junk and must not reach memory
        store_pair(32'h200, 32'hCCCCCC11, MEM_BYTE, 32'h201, 32'hCCCCCC22, MEM_BYTE);
        store_one(32'h202, 32'hCCCC4433, MEM_HALF);
        run_load(32'h200, MEM_WORD, model_tail, got);
        check_value(got, 32'h44332211, "merged word");
        run_load(32'h201, MEM_BYTE, model_tail, got);
        run_load(32'h203, MEM_BYTE, model_tail, got);
        run_load(32'h200, MEM_HALF, model_tail, got);
        run_load(32'h202, MEM_HALF, model_tail, got);
        report_test("merge", err_start);
    endtask

    task automatic test_ordering();
        int          err_start = errors;
        int          start_count;
        sq_index_t   idx;
        logic [31:0] got;
        idx = model_tail;
        dispatch_stores(2);
        issue_store(idx, 32'h300, 32'hAAAA0001, MEM_WORD);
        issue_store(idx + sq_index_t'(1), 32'h300, 32'hBBBB0002, MEM_WORD);
        start_count = done_count;
        fork
            run_load(32'h300, MEM_WORD, model_tail, got);  // snapshot behind both stores
            begin
                retire_store();
                check_value(32'(done_count - start_count), 32'd0, "done count after retire 1");
                retire_store();
                check_value(32'(done_count - start_count), 32'd0, "done count after retire 2");
            end
        join
        check_value(got, 32'hBBBB0002, "load behind two stores");
        report_test("ordering", err_start);
    endtask

    task automatic test_squash();
        int          err_start = errors;
        sq_index_t   idx;
        sq_index_t   br_point;
        logic [31:0] got;
        store_pair(32'h508, 32'h5A5A0008, MEM_WORD, 32'h50C, 32'h5A5A000C, MEM_WORD);
        idx = model_tail;
        dispatch_stores(2);
        issue_store(idx, 32'h500, 32'h11110500, MEM_WORD);
        issue_store(idx + sq_index_t'(1), 32'h504, 32'h22220504, MEM_WORD);
        br_point = model_tail;
        repeat (3) dispatch_stores(2);  // wrong path fills the queue
        issue_store(br_point, 32'h508, 32'hBAD00508, MEM_WORD);
        issue_store(br_point + sq_index_t'(1), 32'h50C, 32'hBAD0050C, MEM_WORD);
        @(negedge clock);
        check_value(32'(open_entries), 32'd0, "open_entries with a full queue");
        @(posedge clock);
        br_en   <= 1'b1;
        br_tail <= br_point;
        @(posedge clock);
        br_en <= 1'b0;
        model_tail = br_point;
        @(negedge clock);
        check_value(32'(open_entries), 32'(`SQ_DISPATCH_WIDTH), "open_entries after squash");
        check_value(32'(sq_tail), 32'(br_point), "sq_tail after squash");
        retire_store();
        retire_store();
        @(negedge clock);
        check_value(32'(sq_head), 32'(model_tail), "sq_head once drained");
        run_load(32'h500, MEM_WORD, model_tail, got);
        run_load(32'h504, MEM_WORD, model_tail, got);
        run_load(32'h508, MEM_WORD, model_tail, got);
        check_value(got, 32'h5A5A0008, "word under a squashed store");
        run_load(32'h50C, MEM_WORD, model_tail, got);
        report_test("squash", err_start);
    endtask

    task automatic test_random();
        int          err_start = errors;
        logic [31:0] a [2];
        logic [31:0] d [2];
        mem_size_t   s [2];
        logic [31:0] r;
        logic [31:0] got;
        // sixteen words at 0x400 get a full value first so every byte is known
        for (int w = 0; w < 16; w += 2) begin
            store_pair(32'h400 + 32'(w) * 4, lcg_next(), MEM_WORD,
                       32'h404 + 32'(w) * 4, lcg_next(), MEM_WORD);
        end
        for (int p = 0; p < 20; p++) begin
            for (int k = 0; k < 2; k++) begin
                r = lcg_next();
                case (r[17:16])
                    2'd0:    s[k] = MEM_BYTE;
                    2'd1:    s[k] = MEM_HALF;
                    default: s[k] = MEM_WORD;
                endcase
                // aligned to its size inside the 64-byte window
                a[k] = (32'h400 + {26'd0, r[29:24]}) & ~(32'(size_bytes(s[k])) - 32'd1);
                d[k] = lcg_next();
            end
            store_pair(a[0], d[0], s[0], a[1], d[1], s[1]);
        end
        for (int w = 0; w < 16; w++) begin
            run_load(32'h400 + 32'(w) * 4, MEM_WORD, model_tail, got);
        end
        report_test("random", err_start);
    endtask

    initial begin
        reset                = 1'b1;
        num_store_dispatched = '0;
        issue_valid          = 1'b0;
        issue_pkt            = '0;
        start_store          = 1'b0;
        br_en                = 1'b0;
        br_tail              = '0;
        load_valid           = 1'b0;
        load_req             = '0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        test_reset();
        test_word();
        test_merge();
        test_ordering();
        test_squash();
        test_random();
        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/store_queue_mem_checker.sv ====
`timescale 1ns/1ps
`include "sq_defs.svh"

module store_queue_mem_checker (
    input logic                                    clock,
    input logic                                    reset,
    input logic                                    start_store,
    input logic                                    load_grant,  // internal arbiter output
    input logic                                    load_done,
    input logic [$clog2(`SQ_DISPATCH_WIDTH+1)-1:0] open_entries
);

    // a load spends exactly one cycle in the read state, so done is a single pulse
    done_single: assert property (@(posedge clock) disable iff (reset)
        load_done |=> !load_done)
        else $error("load_done stayed high for two cycles in a row");

    // the retiring store owns the memory port, a load must never get it in that cycle
    store_wins: assert property (@(posedge clock) disable iff (reset)
        !(load_grant && start_store))
        else $error("load granted while a store was retiring");

    open_capped: assert property (@(posedge clock) disable iff (reset)
        32'(open_entries) <= `SQ_DISPATCH_WIDTH)  // never more than one dispatch group
        else $error("open_entries above the dispatch width");

endmodule

// watch the top level from inside, load_grant is only visible there
bind store_queue_mem_top store_queue_mem_checker i_checker (
    .clock, .reset, .start_store, .load_grant, .load_done, .open_entries
);

// ==== hdl/store_queue_mem_top.sv ====
`timescale 1ns/1ps
`include "sq_defs.svh"

module store_queue_mem_top (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [$clog2(`SQ_DISPATCH_WIDTH+1)-1:0]  num_store_dispatched,
    input  logic                                     issue_valid,
    input  sq_pkg::sq_issue_t                        issue_pkt,
    input  logic                                     start_store,
    input  logic                                     br_en,
    input  sq_pkg::sq_index_t                        br_tail,
    output logic [$clog2(`SQ_DISPATCH_WIDTH+1)-1:0]  open_entries,
    output sq_pkg::sq_index_t                        sq_head,
    output sq_pkg::sq_index_t                        sq_tail,
    input  logic                                     load_valid,
    input  sq_pkg::ld_req_t                          load_req,
    output logic                                     load_ready,
    output logic                                     load_done,
    output logic [`SQ_DATA_WIDTH-1:0]                load_data
);

    import sq_pkg::*;

    logic                      store_req_valid;
    mem_req_t                  store_req;
    logic                      load_mem_valid;
    mem_req_t                  load_mem_req;
    logic                      load_grant;
    logic                      mem_valid;    // the one memory port after arbitration
    mem_req_t                  mem_req;
    logic [`SQ_DATA_WIDTH-1:0] rdata;

    store_queue i_store_queue (
        .clock, .reset, .num_store_dispatched, .issue_valid, .issue_pkt,
        .start_store, .br_en, .br_tail, .open_entries, .sq_head, .sq_tail,
        .store_req_valid, .store_req
    );

    // the load unit watches the same head that the top level reports
    load_unit i_load_unit (
        .clock, .reset, .load_valid, .load_req, .load_ready, .sq_head,
        .load_mem_valid, .load_mem_req, .load_grant, .rdata, .load_done, .load_data
    );

    mem_arbiter i_mem_arbiter (
        .store_req_valid, .store_req, .load_mem_valid, .load_mem_req,
        .load_grant, .mem_valid, .mem_req
    );

    data_memory i_data_memory (
        .clock, .reset, .mem_valid, .mem_req, .rdata
    );

endmodule

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ps
`include "sq_defs.svh"

module data_memory (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      mem_valid,
    input  sq_pkg::mem_req_t          mem_req,
    output logic [`SQ_DATA_WIDTH-1:0] rdata
);

    import sq_pkg::*;

    localparam int unsigned IDX_W   = $clog2(`SQ_MEM_WORDS);
    localparam int unsigned N_BYTES = `SQ_DATA_WIDTH / 8;

    logic [`SQ_DATA_WIDTH-1:0] mem [`SQ_MEM_WORDS];
    logic [IDX_W-1:0]          word_idx;
    logic [N_BYTES-1:0]        byte_en;
    logic [`SQ_DATA_WIDTH-1:0] wdata;

    // word index drops the byte offset, upper address bits wrap around
    assign word_idx = mem_req.addr[IDX_W+1:2];

    // lane select is little-endian, byte 0 sits in bits 7:0
    always_comb begin
        case (mem_req.size)
            MEM_BYTE: byte_en = N_BYTES'(4'b0001) << mem_req.addr[1:0];
            MEM_HALF: byte_en = N_BYTES'(4'b0011) << mem_req.addr[1:0];
            default:  byte_en = '1;
        endcase
        wdata = mem_req.data << {mem_req.addr[1:0], 3'b000};  // line the data up with its lanes
    end

    always_ff @(posedge clock) begin
        if (mem_valid && mem_req.write) begin
            for (int b = 0; b < N_BYTES; b++) begin
                if (byte_en[b]) mem[word_idx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // reads return the whole word a cycle later, the load unit picks the lanes
    always_ff @(posedge clock) begin
        if (reset) begin
            rdata <= '0;
        end else if (mem_valid && !mem_req.write) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic             store_req_valid,
    input  sq_pkg::mem_req_t store_req,
    input  logic             load_mem_valid,
    input  sq_pkg::mem_req_t load_mem_req,
    output logic             load_grant,
    output logic             mem_valid,
    output sq_pkg::mem_req_t mem_req
);

    // the store always wins, retire can never be held off by a load
    assign load_grant = load_mem_valid && !store_req_valid;
    assign mem_valid  = store_req_valid || load_mem_valid;

    always_comb begin
        if (store_req_valid) begin
            mem_req = store_req;
        end else begin
            mem_req = load_mem_req;  // also the idle value, harmless with mem_valid low
        end
    end

endmodule

// ==== hdl/load_unit.sv ====
`timescale 1ns/1ps
`include "sq_defs.svh"

module load_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      load_valid,
    input  sq_pkg::ld_req_t           load_req,
    output logic                      load_ready,
    input  sq_pkg::sq_index_t         sq_head,
    output logic                      load_mem_valid,
    output sq_pkg::mem_req_t          load_mem_req,
    input  logic                      load_grant,
    input  logic [`SQ_DATA_WIDTH-1:0] rdata,
    output logic                      load_done,
    output logic [`SQ_DATA_WIDTH-1:0] load_data
);

    import sq_pkg::*;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT,  // holding a load, older stores may still be in the queue
        LD_READ   // memory was read at the last edge, rdata is valid now
    } ld_state_t;

    ld_state_t                 state;
    ld_state_t                 state_next;
    ld_req_t                   req;      // the one load held here
    logic [`SQ_DATA_WIDTH-1:0] shifted;

    // a new load can be taken while the previous one finishes
    assign load_ready = (state != LD_WAIT);
    assign load_done  = (state == LD_READ);

    // once head reaches the snapshot every older store has been written
    assign load_mem_valid = (state == LD_WAIT) && (sq_head == req.sq_tail);

    always_comb begin
        load_mem_req.write = 1'b0;
        load_mem_req.addr  = req.addr;
        load_mem_req.data  = '0;
        load_mem_req.size  = req.size;
    end

    always_comb begin
        state_next = state;
        case (state)
            LD_IDLE: if (load_valid) state_next = LD_WAIT;
            LD_WAIT: if (load_mem_valid && load_grant) state_next = LD_READ;
            LD_READ: state_next = load_valid ? LD_WAIT : LD_IDLE;
            default: state_next = LD_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) state <= LD_IDLE;
        else state <= state_next;
    end

    always_ff @(posedge clock) begin
        if (load_valid && load_ready) req <= load_req;
    end

    // move the addressed byte lane down to bit 0, then zero-extend by size
    always_comb begin
        shifted = rdata >> {req.addr[1:0], 3'b000};
        case (req.size)
            MEM_BYTE: load_data = `SQ_DATA_WIDTH'(shifted[7:0]);
            MEM_HALF: load_data = `SQ_DATA_WIDTH'(shifted[15:0]);
            default:  load_data = shifted;
        endcase
    end

endmodule

// ==== hdl/store_queue.sv ====
`timescale 1ns/1ps
`include "sq_defs.svh"

module store_queue (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [$clog2(`SQ_DISPATCH_WIDTH+1)-1:0]  num_store_dispatched,
    input  logic                                     issue_valid,
    input  sq_pkg::sq_issue_t                        issue_pkt,
    input  logic                                     start_store,
    input  logic                                     br_en,
    input  sq_pkg::sq_index_t                        br_tail,
    output logic [$clog2(`SQ_DISPATCH_WIDTH+1)-1:0]  open_entries,
    output sq_pkg::sq_index_t                        sq_head,
    output sq_pkg::sq_index_t                        sq_tail,
    output logic                                     store_req_valid,
    output sq_pkg::mem_req_t                         store_req
);

    import sq_pkg::*;

    localparam int unsigned CNT_W  = $clog2(`SQ_DEPTH + 1);
    localparam int unsigned OPEN_W = $clog2(`SQ_DISPATCH_WIDTH + 1);

    sq_entry_t        entries [`SQ_DEPTH];  // slot payloads, only written by issue
    sq_index_t        head;                 // oldest allocated slot
    sq_index_t        tail;                 // one past the youngest allocated slot
    sq_index_t        head_next;
    sq_index_t        tail_next;
    sq_index_t        squash_dist;
    logic [CNT_W-1:0] count;                // allocated slots, issued or not
    logic [CNT_W-1:0] count_next;
    logic [CNT_W-1:0] free_slots;
    logic [CNT_W-1:0] squashed;

    assign sq_head = head;
    assign sq_tail = tail;

    // free slots capped at the dispatch width, exact with no slot held back
    assign free_slots   = CNT_W'(`SQ_DEPTH) - count;
    assign open_entries = (free_slots > CNT_W'(`SQ_DISPATCH_WIDTH)) ?
                          OPEN_W'(`SQ_DISPATCH_WIDTH) : OPEN_W'(free_slots);

    // distance from the branch tail up to the current tail, wraps on the index width
    assign squash_dist = tail - br_tail;
    assign squashed    = br_en ? CNT_W'(squash_dist) : '0;

    always_comb begin
        // squash first so that stores dispatched this cycle land behind the branch
        tail_next  = (br_en ? br_tail : tail) + sq_index_t'(num_store_dispatched);
        head_next  = start_store ? head + sq_index_t'(1) : head;
        count_next = count - squashed + CNT_W'(num_store_dispatched) - CNT_W'(start_store);
    end

    // the retiring store goes straight to the arbiter, so its write lands at this same edge
    assign store_req_valid = start_store;

    always_comb begin
        store_req.write = 1'b1;
        store_req.addr  = entries[head].addr;
        store_req.data  = entries[head].data;
        store_req.size  = entries[head].size;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head_next;
            tail  <= tail_next;
            count <= count_next;
        end
    end

    // issue may arrive any time after allocation and fills its own slot
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            entries[issue_pkt.index].addr <= issue_pkt.base + issue_pkt.offset;  // address add
            entries[issue_pkt.index].data <= issue_pkt.data;
            entries[issue_pkt.index].size <= issue_pkt.size;
        end
    end

endmodule

// ==== hdl/sq_pkg.sv ====
`include "sq_defs.svh"

package sq_pkg;

    // access size, encoded like the low two funct3 bits of a load or store
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    typedef logic [$clog2(`SQ_DEPTH)-1:0] sq_index_t;  // one store queue slot

    // store coming out of issue, the slot index was handed out at dispatch
    typedef struct packed {
        sq_index_t                 index;
        logic [`SQ_ADDR_WIDTH-1:0] base;
        logic [`SQ_ADDR_WIDTH-1:0] offset;
        logic [`SQ_DATA_WIDTH-1:0] data;
        mem_size_t                 size;
    } sq_issue_t;

    // what a slot keeps once its address has been formed
    typedef struct packed {
        logic [`SQ_ADDR_WIDTH-1:0] addr;
        logic [`SQ_DATA_WIDTH-1:0] data;
        mem_size_t                 size;
    } sq_entry_t;

    typedef struct packed {
        logic [`SQ_ADDR_WIDTH-1:0] addr;
        mem_size_t                 size;
        sq_index_t                 sq_tail;  // tail seen at dispatch, marks the youngest older store
    } ld_req_t;

    // one access on the shared memory port
    typedef struct packed {
        logic                      write;
        logic [`SQ_ADDR_WIDTH-1:0] addr;
        logic [`SQ_DATA_WIDTH-1:0] data;  // ignored for reads
        mem_size_t                 size;
    } mem_req_t;

endpackage

// ==== hdl/sq_defs.svh ====
`ifndef SQ_DEFS_SVH
`define SQ_DEFS_SVH

// number of store queue slots, kept a power of two so the pointers wrap on their own width
`define SQ_DEPTH 8

// the most stores that dispatch can allocate in one cycle
`define SQ_DISPATCH_WIDTH 2

`define SQ_ADDR_WIDTH 32  // byte address
`define SQ_DATA_WIDTH 32

// data memory size in 32-bit words, addresses wrap modulo its byte size
`define SQ_MEM_WORDS 256

`endif
